// File: design/vga_timing_pkg.sv
// widths for the modeline inputs and counters; sums of all porches must fit in 16 bits
package vga_timing_pkg;

   ////////////////////
   // widths
   ////////////////////

   localparam int COORD_W = 16; // visible size and counter positions
   localparam int PORCH_W = 8;  // porches and sync widths

   ////////////////////
   // types
   ////////////////////

   typedef logic [COORD_W-1:0] coord_t;
   typedef logic [PORCH_W-1:0] porch_t;

endpackage

// File: design/vga_vram_pkg.sv
// colour, bank and queue definitions; bank depth is kept small and must stay a power of two
package vga_vram_pkg;

   ////////////////////
   // pixel format
   ////////////////////

   localparam int RGB_W = 24;            // r in [23:16], g in [15:8], b in [7:0]
   typedef logic [RGB_W-1:0] rgb_t;

   localparam rgb_t NO_VRAM_COLOR = 24'hFF0000; // fill on underflow

   ////////////////////
   // banks and lanes
   ////////////////////

   localparam int NUM_LANES  = 4;  // writer pixels per clock
   localparam int NUM_BANKS  = 6;
   localparam int BANK_DEPTH = 16;
   localparam int BANK_PTR_W = $clog2(BANK_DEPTH);

   typedef logic [2:0]            bank_idx_t;  // 0 .. NUM_BANKS-1
   typedef logic [BANK_PTR_W-1:0] bank_ptr_t;
   typedef logic [BANK_PTR_W:0]   used_t;      // one more bit so a full bank fits

   ////////////////////
   // accounting
   ////////////////////

   localparam int COUNT_W   = 24;
   localparam int MAX_BURST = 8;   // room a writer burst needs

   typedef logic [COUNT_W-1:0] queue_t;
   typedef logic [COUNT_W-1:0] pix_count_t;

   localparam queue_t READY_LEVEL = queue_t'(NUM_BANKS * BANK_DEPTH - MAX_BURST);

endpackage

// File: design/vga_timing_gen.sv
// progressive timing only; counters start at the visible area and advance on i_ce_pix alone
`timescale 1ns/100ps

module vga_timing_gen (
   input  logic                   i_clk_sys,
   input  logic                   i_vga_reset,
   input  logic                   i_ce_pix,
   input  vga_timing_pkg::coord_t i_h,
   input  vga_timing_pkg::porch_t i_hfp,
   input  vga_timing_pkg::porch_t i_hs,
   input  vga_timing_pkg::porch_t i_hbp,
   input  vga_timing_pkg::coord_t i_v,
   input  vga_timing_pkg::porch_t i_vfp,
   input  vga_timing_pkg::porch_t i_vs,
   input  vga_timing_pkg::porch_t i_vbp,
   output vga_timing_pkg::coord_t o_h_cnt,
   output vga_timing_pkg::coord_t o_v_cnt,
   output logic                   o_hsync,
   output logic                   o_vsync,
   output logic                   o_hblank,
   output logic                   o_vblank,
   output logic                   o_de
);

   vga_timing_pkg::coord_t h_cnt;
   vga_timing_pkg::coord_t v_cnt;
   vga_timing_pkg::coord_t h_sync_start;
   vga_timing_pkg::coord_t h_sync_end;
   vga_timing_pkg::coord_t h_last;
   vga_timing_pkg::coord_t v_sync_start;
   vga_timing_pkg::coord_t v_sync_end;
   vga_timing_pkg::coord_t v_last;
   logic                   hs_n;  // sync kept active low
   logic                   vs_n;
   logic                   hb;
   logic                   vb;

   ////////////////////
   // modeline limits
   ////////////////////

   assign h_sync_start = i_h + vga_timing_pkg::coord_t'(i_hfp);
   assign h_sync_end   = h_sync_start + vga_timing_pkg::coord_t'(i_hs);
   assign h_last       = h_sync_end + vga_timing_pkg::coord_t'(i_hbp) - 16'd1;

   assign v_sync_start = i_v + vga_timing_pkg::coord_t'(i_vfp);
   assign v_sync_end   = v_sync_start + vga_timing_pkg::coord_t'(i_vs);
   assign v_last       = v_sync_end + vga_timing_pkg::coord_t'(i_vbp) - 16'd1;

   // horizontal
   always_ff @(posedge i_clk_sys) begin
      if (i_vga_reset) begin
         h_cnt <= '0;
         hs_n  <= 1'b1;
         hb    <= 1'b1;
      end else if (i_ce_pix) begin
         if (h_cnt >= h_last) begin
            h_cnt <= '0;
         end else begin
            h_cnt <= h_cnt + 16'd1;
         end
         hs_n <= !((h_cnt >= h_sync_start) && (h_cnt < h_sync_end)); // one ce late
         hb   <= (h_cnt >= i_h);
      end
   end

   // vertical steps where hsync starts
   always_ff @(posedge i_clk_sys) begin
      if (i_vga_reset) begin
         v_cnt <= '0;
         vs_n  <= 1'b1;
         vb    <= 1'b1;
      end else if (i_ce_pix && (h_cnt == h_sync_start)) begin
         if (v_cnt >= v_last) begin
            v_cnt <= '0;
         end else begin
            v_cnt <= v_cnt + 16'd1;
         end
         vb   <= (v_cnt >= i_v);
         vs_n <= !((v_cnt >= v_sync_start) && (v_cnt < v_sync_end));
      end
   end

   assign o_h_cnt  = h_cnt;
   assign o_v_cnt  = v_cnt;
   assign o_hsync  = hs_n;
   assign o_vsync  = vs_n;
   assign o_hblank = hb;
   assign o_vblank = vb;
   assign o_de     = !(hb || vb);

endmodule

// File: design/vram_bank_fifo.sv
// single clock show-ahead FIFO; a write to a full bank is dropped and a read of an empty one ignored
`timescale 1ns/100ps

module vram_bank_fifo (
   input  logic               i_clk_sys,
   input  logic               i_clear,
   input  logic               i_wr,
   input  vga_vram_pkg::rgb_t i_data,
   input  logic               i_rd,
   output vga_vram_pkg::rgb_t o_data,
   output logic               o_empty,
   output logic               o_full,
   output vga_vram_pkg::used_t o_used
);

   vga_vram_pkg::rgb_t      mem [vga_vram_pkg::BANK_DEPTH];
   vga_vram_pkg::bank_ptr_t wr_ptr;
   vga_vram_pkg::bank_ptr_t rd_ptr;
   vga_vram_pkg::used_t     used;
   logic                    do_wr;
   logic                    do_rd;

   assign o_empty = (used == '0);
   assign o_full  = (used == vga_vram_pkg::used_t'(vga_vram_pkg::BANK_DEPTH));
   assign do_wr   = i_wr && !o_full;
   assign do_rd   = i_rd && !o_empty;

   assign o_data = mem[rd_ptr]; // head valid while not empty
   assign o_used = used;

   always_ff @(posedge i_clk_sys) begin
      if (do_wr) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // pointers wrap on their own width
   always_ff @(posedge i_clk_sys) begin
      if (i_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         used <= used + vga_vram_pkg::used_t'(do_wr) - vga_vram_pkg::used_t'(do_rd);
      end
   end

endmodule

// File: design/vram_write_distributor.sv
// wren must be contiguous from lane 0; strobes are combinational so the bank sees a write next clock
`timescale 1ns/100ps

module vram_write_distributor (
   input  logic                                    i_clk_sys,
   input  logic                                    i_clear,
   input  logic [vga_vram_pkg::NUM_LANES-1:0]      i_vram_wren,
   input  vga_vram_pkg::rgb_t                      i_vram_rgb [vga_vram_pkg::NUM_LANES],
   input  vga_vram_pkg::pix_count_t                i_frame_pixels,
   output logic [vga_vram_pkg::NUM_BANKS-1:0]      o_bank_wr,
   output vga_vram_pkg::rgb_t                      o_bank_data [vga_vram_pkg::NUM_BANKS],
   output vga_vram_pkg::pix_count_t                o_vram_pixels,
   output logic                                    o_vram_end_frame
);

   vga_vram_pkg::bank_idx_t  wr_ptr;
   vga_vram_pkg::bank_idx_t  lane_bank [vga_vram_pkg::NUM_LANES];
   logic [2:0]               lane_cnt;   // pixels this clock
   vga_vram_pkg::pix_count_t pix_cnt;

   // bank index plus a step, modulo the bank count
   function automatic vga_vram_pkg::bank_idx_t bank_step(input vga_vram_pkg::bank_idx_t base,
                                                          input logic [2:0] step);
      logic [3:0] sum;
      sum = {1'b0, base} + {1'b0, step};
      if (sum >= 4'(vga_vram_pkg::NUM_BANKS)) begin
         sum = sum - 4'(vga_vram_pkg::NUM_BANKS);
      end
      return sum[2:0];
   endfunction

   always_comb begin
      lane_cnt = '0;
      for (int k = 0; k < vga_vram_pkg::NUM_LANES; k++) begin
         lane_bank[k] = bank_step(wr_ptr, 3'(k));
         lane_cnt     = lane_cnt + 3'(i_vram_wren[k]);
      end
   end

   ////////////////////
   // lane to bank map
   ////////////////////

   always_comb begin
      for (int b = 0; b < vga_vram_pkg::NUM_BANKS; b++) begin
         o_bank_wr[b]   = 1'b0;
         o_bank_data[b] = i_vram_rgb[0];
         for (int k = 0; k < vga_vram_pkg::NUM_LANES; k++) begin
            if (i_vram_wren[k] && (lane_bank[k] == vga_vram_pkg::bank_idx_t'(b))) begin
               o_bank_wr[b]   = 1'b1;
               o_bank_data[b] = i_vram_rgb[k];
            end
         end
      end
   end

   // rotate pointer, count frame pixels
   always_ff @(posedge i_clk_sys) begin
      if (i_clear) begin
         wr_ptr  <= '0;
         pix_cnt <= '0;
      end else if (lane_cnt != '0) begin
         wr_ptr <= bank_step(wr_ptr, lane_cnt);
         if (o_vram_end_frame) begin
            pix_cnt <= vga_vram_pkg::pix_count_t'(lane_cnt); // next frame starts
         end else begin
            pix_cnt <= pix_cnt + vga_vram_pkg::pix_count_t'(lane_cnt);
         end
      end
   end

   assign o_vram_pixels    = pix_cnt;
   assign o_vram_end_frame = (pix_cnt >= i_frame_pixels);

endmodule

// File: design/vram_read_sequencer.sv
// VRAM output arms in a vblank with a non-empty queue; the lost-sync flag only clears on a reset
`timescale 1ns/100ps

module vram_read_sequencer (
   input  logic                               i_clk_sys,
   input  logic                               i_vga_reset,
   input  logic                               i_vram_reset,
   input  logic                               i_ce_pix,
   input  logic                               i_vram_active,
   input  logic                               i_de,
   input  logic                               i_vblank,
   input  vga_vram_pkg::rgb_t                 i_rgb_in,
   input  vga_vram_pkg::rgb_t                 i_bank_data [vga_vram_pkg::NUM_BANKS],
   input  logic [vga_vram_pkg::NUM_BANKS-1:0] i_bank_empty,
   input  vga_vram_pkg::queue_t               i_queue,
   output logic [vga_vram_pkg::NUM_BANKS-1:0] o_bank_rd,
   output vga_vram_pkg::rgb_t                 o_pixel,
   output logic                               o_vram_synced
);

   vga_vram_pkg::bank_idx_t rd_ptr;
   logic                    vram_run;   // output started
   logic                    sync_lost;
   logic                    vram_slot;  // enabled visible cycle while running
   logic                    head_ok;
   vga_vram_pkg::rgb_t      pixel;

   assign vram_slot = i_ce_pix && i_vram_active && i_de && vram_run;
   assign head_ok   = !i_bank_empty[rd_ptr];

   always_comb begin
      for (int b = 0; b < vga_vram_pkg::NUM_BANKS; b++) begin
         o_bank_rd[b] = vram_slot && head_ok && (rd_ptr == vga_vram_pkg::bank_idx_t'(b));
      end
   end

   ////////////////////
   // read control
   ////////////////////

   always_ff @(posedge i_clk_sys) begin
      if (i_vga_reset || i_vram_reset) begin
         rd_ptr    <= '0;
         vram_run  <= 1'b0;
         sync_lost <= 1'b0;
      end else if (i_ce_pix && i_vram_active) begin
         if (i_vblank && (i_queue != '0)) begin
            vram_run <= 1'b1; // first line of the next frame
         end
         if (vram_slot) begin
            if (!head_ok) begin
               sync_lost <= 1'b1;
            end else if (rd_ptr == vga_vram_pkg::bank_idx_t'(vga_vram_pkg::NUM_BANKS - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 3'd1;
            end
         end
      end
   end

   // pixel out, zero in blanking
   always_ff @(posedge i_clk_sys) begin
      if (i_vga_reset) begin
         pixel <= '0;
      end else if (i_ce_pix) begin
         if (!i_de) begin
            pixel <= '0;
         end else if (!i_vram_active) begin
            pixel <= i_rgb_in;                   // direct mode
         end else if (!vram_run) begin
            pixel <= '0;
         end else if (head_ok) begin
            pixel <= i_bank_data[rd_ptr];
         end else begin
            pixel <= vga_vram_pkg::NO_VRAM_COLOR; // underflow
         end
      end
   end

   assign o_pixel       = pixel;
   assign o_vram_synced = !sync_lost;

endmodule

// File: design/vga_vram_top.sv
// writer must honour o_vram_ready; o_vga_pixels is taken from the modeline only on a reset
`timescale 1ns/100ps

module vga_vram_top (
   input  logic                               i_clk_sys,
   input  logic                               vga_reset,
   input  logic                               i_ce_pix,
   input  logic                               i_vram_reset,
   input  logic                               i_vram_active,
   input  vga_timing_pkg::coord_t             i_h,
   input  vga_timing_pkg::porch_t             i_hfp,
   input  vga_timing_pkg::porch_t             i_hs,
   input  vga_timing_pkg::porch_t             i_hbp,
   input  vga_timing_pkg::coord_t             i_v,
   input  vga_timing_pkg::porch_t             i_vfp,
   input  vga_timing_pkg::porch_t             i_vs,
   input  vga_timing_pkg::porch_t             i_vbp,
   input  logic [vga_vram_pkg::NUM_LANES-1:0] i_vram_wren,
   input  vga_vram_pkg::rgb_t                 i_vram_rgb [vga_vram_pkg::NUM_LANES],
   input  vga_vram_pkg::rgb_t                 i_rgb_in,
   output logic                               o_hsync,
   output logic                               o_vsync,
   output logic                               o_hblank,
   output logic                               o_vblank,
   output logic                               o_vga_de,
   output vga_timing_pkg::coord_t             o_vcount,
   output logic [7:0]                         o_r,
   output logic [7:0]                         o_g,
   output logic [7:0]                         o_b,
   output logic                               o_vram_ready,
   output vga_vram_pkg::queue_t               o_vram_queue,
   output vga_vram_pkg::pix_count_t           o_vram_pixels,
   output logic                               o_vram_end_frame,
   output logic                               o_vram_synced,
   output vga_vram_pkg::pix_count_t           o_vga_pixels
);

   logic                               bank_clear;
   logic                               vblank;
   logic                               de;
   logic [vga_vram_pkg::NUM_BANKS-1:0] bank_wr;
   logic [vga_vram_pkg::NUM_BANKS-1:0] bank_rd;
   logic [vga_vram_pkg::NUM_BANKS-1:0] bank_empty;
   logic [vga_vram_pkg::NUM_BANKS-1:0] bank_full;
   vga_vram_pkg::rgb_t                 bank_wdata [vga_vram_pkg::NUM_BANKS];
   vga_vram_pkg::rgb_t                 bank_rdata [vga_vram_pkg::NUM_BANKS];
   vga_vram_pkg::used_t                bank_used  [vga_vram_pkg::NUM_BANKS];
   vga_vram_pkg::queue_t               queue_sum;
   vga_vram_pkg::pix_count_t           vga_pixels;
   vga_vram_pkg::rgb_t                 pixel;

   assign bank_clear = vga_reset || i_vram_reset;

   // pixels per frame
   always_ff @(posedge i_clk_sys) begin
      if (bank_clear) begin
         vga_pixels <= vga_vram_pkg::pix_count_t'(i_h) * vga_vram_pkg::pix_count_t'(i_v);
      end
   end

   vga_timing_gen u_timing (
      .i_clk_sys (i_clk_sys),
      .i_vga_reset (vga_reset),
      .i_ce_pix (i_ce_pix),
      .i_h (i_h),
      .i_hfp (i_hfp),
      .i_hs (i_hs),
      .i_hbp (i_hbp),
      .i_v (i_v),
      .i_vfp (i_vfp),
      .i_vs (i_vs),
      .i_vbp (i_vbp),
      .o_h_cnt (),
      .o_v_cnt (o_vcount),
      .o_hsync (o_hsync),
      .o_vsync (o_vsync),
      .o_hblank (o_hblank),
      .o_vblank (vblank),
      .o_de (de)
   );

   vram_write_distributor u_distributor (
      .i_clk_sys (i_clk_sys),
      .i_clear (bank_clear),
      .i_vram_wren (i_vram_wren),
      .i_vram_rgb (i_vram_rgb),
      .i_frame_pixels (vga_pixels),
      .o_bank_wr (bank_wr),
      .o_bank_data (bank_wdata),
      .o_vram_pixels (o_vram_pixels),
      .o_vram_end_frame (o_vram_end_frame)
   );

   ////////////////////
   // bank FIFOs
   ////////////////////

   for (genvar b = 0; b < vga_vram_pkg::NUM_BANKS; b++) begin : g_bank
      vram_bank_fifo u_fifo (
         .i_clk_sys (i_clk_sys),
         .i_clear (bank_clear),
         .i_wr (bank_wr[b]),
         .i_data (bank_wdata[b]),
         .i_rd (bank_rd[b]),
         .o_data (bank_rdata[b]),
         .o_empty (bank_empty[b]),
         .o_full (bank_full[b]),
         .o_used (bank_used[b])
      );
   end

   always_comb begin
      queue_sum = '0;
      for (int b = 0; b < vga_vram_pkg::NUM_BANKS; b++) begin
         queue_sum = queue_sum + vga_vram_pkg::queue_t'(bank_used[b]);
      end
   end

   vram_read_sequencer u_sequencer (
      .i_clk_sys (i_clk_sys),
      .i_vga_reset (vga_reset),
      .i_vram_reset (i_vram_reset),
      .i_ce_pix (i_ce_pix),
      .i_vram_active (i_vram_active),
      .i_de (de),
      .i_vblank (vblank),
      .i_rgb_in (i_rgb_in),
      .i_bank_data (bank_rdata),
      .i_bank_empty (bank_empty),
      .i_queue (queue_sum),
      .o_bank_rd (bank_rd),
      .o_pixel (pixel),
      .o_vram_synced (o_vram_synced)
   );

   assign o_vblank     = vblank;
   assign o_vga_de     = de;
   assign o_r          = pixel[23:16];
   assign o_g          = pixel[15:8];
   assign o_b          = pixel[7:0];
   assign o_vram_queue = queue_sum;
   assign o_vram_ready = (queue_sum < vga_vram_pkg::READY_LEVEL); // headroom
   assign o_vga_pixels = vga_pixels;

endmodule

// File: verification/vga_vram_assertions.sv
// bound to vga_vram_top; all checks are masked while vga_reset is high
`timescale 1ns/100ps

module vga_vram_assertions (
   input logic                               i_clk_sys,
   input logic                               i_vga_reset,
   input logic                               i_vram_reset,
   input logic [vga_vram_pkg::NUM_LANES-1:0] i_vram_wren,
   input logic [vga_vram_pkg::NUM_BANKS-1:0] i_bank_wr,
   input logic [vga_vram_pkg::NUM_BANKS-1:0] i_bank_full,
   input logic                               i_hsync,
   input logic                               i_de,
   input logic                               i_vram_synced
);

   int unsigned fail_count = 0; // failed assertions so far

   ////////////////////
   // write side
   ////////////////////

   wren_contiguous : assert property (@(posedge i_clk_sys) disable iff (i_vga_reset)
      i_vram_wren inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
      else begin
         fail_count++;
         $error("vram_wren is not contiguous from lane 0");
      end

   no_full_write : assert property (@(posedge i_clk_sys) disable iff (i_vga_reset)
      (i_bank_wr & i_bank_full) == '0)
      else begin
         fail_count++;
         $error("write strobe on a full bank, pixel dropped");
      end

   ////////////////////
   // display side
   ////////////////////

   hsync_in_blank : assert property (@(posedge i_clk_sys) disable iff (i_vga_reset)
      !(!i_hsync && i_de))
      else begin
         fail_count++;
         $error("hsync low during display enable");
      end

   // lost sync comes back only through a reset
   synced_rise : assert property (@(posedge i_clk_sys) disable iff (i_vga_reset)
      $rose(i_vram_synced) |-> $past(i_vga_reset || i_vram_reset))
      else begin
         fail_count++;
         $error("vram_synced rose without a reset");
      end

endmodule

// File: verification/vga_vram_tb.sv
// fixed 8x4 modeline, ce_pix on every other clock; writes only go on the clock between pixel periods
`timescale 1ns/100ps

module vga_vram_tb;

   localparam int H = 8;
   localparam int HFP = 2;
   localparam int HS = 2;
   localparam int HBP = 2;
   localparam int V = 4;
   localparam int VFP = 1;
   localparam int VS = 1;
   localparam int VBP = 1;
   localparam int LINE_LEN = H + HFP + HS + HBP;               // pixel periods per line
   localparam int FRAME_LINES = V + VFP + VS + VBP;
   localparam int FRAME_LEN = LINE_LEN * (V + VFP + VS + VBP); // 98
   localparam int FRAME_PIX = H * V;
   localparam int READY_LEVEL = vga_vram_pkg::NUM_BANKS * vga_vram_pkg::BANK_DEPTH
                                - vga_vram_pkg::MAX_BURST;
   localparam int ROW_FRAMES = 3;
   localparam int NUM_ROWS = 6;
   localparam int CYCLE_LIMIT = NUM_ROWS * ROW_FRAMES * FRAME_LEN * 2 + 200;

   typedef struct packed {
      logic       vram;     // VRAM mode
      logic [7:0] bursts;
      logic [2:0] lanes;    // 0 picks 1..4 per burst
      logic [7:0] exp_vis;  // display enable pixels over the row
   } row_t;

   localparam row_t ROWS [NUM_ROWS] = '{
      '{1'b0, 8'd10, 3'd1, 8'd96},  // direct, single pixels
      '{1'b0, 8'd16, 3'd0, 8'd96},  // mixed lanes, frame count restarts
      '{1'b0, 8'd30, 3'd4, 8'd96},  // runs into the ready level
      '{1'b1, 8'd24, 3'd4, 8'd96},  // VRAM order
      '{1'b1, 8'd6,  3'd2, 8'd96},  // underflow
      '{1'b0, 8'd8,  3'd3, 8'd96}   // synced again after vram_reset
   };

   logic clk_sys;
   logic vga_reset;
   logic ce_pix;
   logic vram_reset;
   logic vram_active;
   logic [vga_vram_pkg::NUM_LANES-1:0] vram_wren;
   vga_vram_pkg::rgb_t vram_rgb [vga_vram_pkg::NUM_LANES];
   vga_vram_pkg::rgb_t rgb_in;
   logic o_hsync, o_vsync, o_hblank, o_vblank, o_vga_de;
   vga_timing_pkg::coord_t o_vcount;
   logic [7:0] o_r, o_g, o_b;
   logic o_vram_ready, o_vram_end_frame, o_vram_synced;
   vga_vram_pkg::queue_t o_vram_queue;
   vga_vram_pkg::pix_count_t o_vram_pixels, o_vga_pixels;

   // reference model state
   vga_vram_pkg::rgb_t ref_q [$];
   vga_vram_pkg::pix_count_t pix_model;
   logic [31:0] rng;
   logic armed, synced_exp, vs_prev, hs_prev, frame_seen;
   int written, popped, bursts_done, row_de, frame_de, hs_low, vs_low, errors, cycles;
   int v_model;

   vga_vram_top DUT (
      .i_clk_sys (clk_sys), .vga_reset (vga_reset), .i_ce_pix (ce_pix),
      .i_vram_reset (vram_reset), .i_vram_active (vram_active),
      .i_h (vga_timing_pkg::coord_t'(H)), .i_hfp (vga_timing_pkg::porch_t'(HFP)),
      .i_hs (vga_timing_pkg::porch_t'(HS)), .i_hbp (vga_timing_pkg::porch_t'(HBP)),
      .i_v (vga_timing_pkg::coord_t'(V)), .i_vfp (vga_timing_pkg::porch_t'(VFP)),
      .i_vs (vga_timing_pkg::porch_t'(VS)), .i_vbp (vga_timing_pkg::porch_t'(VBP)),
      .i_vram_wren (vram_wren), .i_vram_rgb (vram_rgb), .i_rgb_in (rgb_in),
      .o_hsync (o_hsync), .o_vsync (o_vsync), .o_hblank (o_hblank), .o_vblank (o_vblank),
      .o_vga_de (o_vga_de), .o_vcount (o_vcount), .o_r (o_r), .o_g (o_g), .o_b (o_b),
      .o_vram_ready (o_vram_ready), .o_vram_queue (o_vram_queue),
      .o_vram_pixels (o_vram_pixels), .o_vram_end_frame (o_vram_end_frame),
      .o_vram_synced (o_vram_synced), .o_vga_pixels (o_vga_pixels)
   );

   bind vga_vram_top vga_vram_assertions u_assertions (
      .i_clk_sys (i_clk_sys), .i_vga_reset (vga_reset), .i_vram_reset (i_vram_reset),
      .i_vram_wren (i_vram_wren), .i_bank_wr (bank_wr), .i_bank_full (bank_full),
      .i_hsync (o_hsync), .i_de (o_vga_de), .i_vram_synced (o_vram_synced)
   );

   initial begin
      clk_sys = 1'b0;
      forever #50 clk_sys = ~clk_sys;
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge clk_sys);
         cycles++;
         if (cycles > CYCLE_LIMIT) begin
            stop_on_error("timeout, the run did not end within the cycle limit");
         end
      end
   end

   ////////////////////
   // checks
   ////////////////////

   task automatic stop_on_error(input string why);
      errors++;
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_rgb(input string name, input vga_vram_pkg::rgb_t got,
                            input vga_vram_pkg::rgb_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input vga_vram_pkg::pix_count_t got,
                              input vga_vram_pkg::pix_count_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   task automatic check_queue(input string name, input vga_vram_pkg::queue_t got,
                              input vga_vram_pkg::queue_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   task automatic check_coord(input string name, input vga_timing_pkg::coord_t got,
                              input vga_timing_pkg::coord_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_write_side();
      if (DUT.u_assertions.fail_count != 0) begin
         stop_on_error("a bound assertion on the DUT failed");
      end
      check_queue("o_vram_queue", o_vram_queue, vga_vram_pkg::queue_t'(written - popped));
      check_bit("o_vram_ready", o_vram_ready, (written - popped) < READY_LEVEL);
      check_count("o_vram_pixels", o_vram_pixels, pix_model);
      check_bit("o_vram_end_frame", o_vram_end_frame,
                pix_model >= vga_vram_pkg::pix_count_t'(FRAME_PIX));
      check_count("o_vga_pixels", o_vga_pixels, vga_vram_pkg::pix_count_t'(FRAME_PIX));
      check_bit("o_vram_synced", o_vram_synced, synced_exp);
   endtask

   // sync widths, sync inside blanking, enable pixels per frame
   task automatic track_timing();
      if (!o_hsync) begin
         hs_low++;
         check_bit("o_hblank", o_hblank, 1'b1);
      end else if (hs_low != 0) begin
         check_count("hsync low periods", vga_vram_pkg::pix_count_t'(hs_low),
                     vga_vram_pkg::pix_count_t'(HS));
         hs_low = 0;
      end
      if (!o_vsync) begin
         vs_low++;
         check_bit("o_vblank", o_vblank, 1'b1);
      end else if (vs_low != 0) begin
         check_count("vsync low periods", vga_vram_pkg::pix_count_t'(vs_low),
                     vga_vram_pkg::pix_count_t'(VS * LINE_LEN));
         vs_low = 0;
      end
      if (vs_prev && !o_vsync) begin
         if (frame_seen) begin
            check_count("enable pixels per frame", vga_vram_pkg::pix_count_t'(frame_de),
                        vga_vram_pkg::pix_count_t'(FRAME_PIX));
         end
         frame_seen = 1'b1;
         frame_de = 0;
      end
      vs_prev = o_vsync;
      // line counter steps where hsync starts
      if (hs_prev && !o_hsync) begin
         v_model = (v_model + 1) % FRAME_LINES;
      end
      hs_prev = o_hsync;
      check_coord("o_vcount", o_vcount, vga_timing_pkg::coord_t'(v_model));
      if (o_vga_de) begin
         frame_de++;
         row_de++;
      end
   endtask

   ////////////////////
   // one pixel period
   ////////////////////

   task automatic pixel_period(input row_t row, input int idx);
      vga_vram_pkg::rgb_t exp_pix;
      int n;
      @(negedge clk_sys);              // enabled clock
      vram_wren = '0;
      vram_reset = 1'b0;
      check_write_side();
      track_timing();
      rng = xorshift32(rng);
      rgb_in = rng[23:0];
      if (!o_vga_de || (vram_active && !armed)) begin
         exp_pix = '0;
      end else if (!vram_active) begin
         exp_pix = rgb_in;
      end else if (ref_q.size() > 0) begin
         exp_pix = ref_q.pop_front();
         popped++;
      end else begin
         exp_pix = vga_vram_pkg::NO_VRAM_COLOR; // underflow
         synced_exp = 1'b0;
      end
      if (vram_active && o_vblank && (written - popped) > 0) begin
         armed = 1'b1;
      end
      ce_pix = 1'b1;
      @(negedge clk_sys);              // write clock
      check_rgb("o_r/o_g/o_b", {o_r, o_g, o_b}, exp_pix);
      check_write_side();
      ce_pix = 1'b0;
      if (idx == 0) begin
         vram_reset = 1'b1;
         vram_active = row.vram;
         ref_q.delete();
         written = 0;
         popped = 0;
         pix_model = '0;
         armed = 1'b0;
         synced_exp = 1'b1;
      end else if ((bursts_done < int'(row.bursts)) && o_vram_ready) begin
         rng = xorshift32(rng);
         n = (row.lanes == 3'd0) ? int'(rng[1:0]) + 1 : int'(row.lanes);
         for (int k = 0; k < vga_vram_pkg::NUM_LANES; k++) begin
            rng = xorshift32(rng);
            vram_rgb[k] = rng[23:0];
            if (k < n) begin
               vram_wren[k] = 1'b1;
               ref_q.push_back(rng[23:0]);
            end
         end
         written += n;
         bursts_done++;
         if (pix_model >= vga_vram_pkg::pix_count_t'(FRAME_PIX)) begin
            pix_model = vga_vram_pkg::pix_count_t'(n); // new frame
         end else begin
            pix_model = pix_model + vga_vram_pkg::pix_count_t'(n);
         end
      end
   endtask

   initial begin
      vga_reset = 1'b1;
      ce_pix = 1'b0;
      vram_reset = 1'b0;
      vram_active = 1'b0;
      vram_wren = '0;
      rgb_in = '0;
      for (int k = 0; k < vga_vram_pkg::NUM_LANES; k++) begin
         vram_rgb[k] = '0;
      end
      rng = 32'd64;
      errors = 0;
      written = 0;
      popped = 0;
      pix_model = '0;
      armed = 1'b0;
      synced_exp = 1'b1;
      hs_low = 0;
      vs_low = 0;
      vs_prev = 1'b1;
      hs_prev = 1'b1;
      v_model = 0;
      frame_de = 0;
      frame_seen = 1'b0;
      repeat (3) @(negedge clk_sys);
      vga_reset = 1'b0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         row_de = 0;
         bursts_done = 0;
         for (int p = 0; p < ROW_FRAMES * FRAME_LEN; p++) begin
            pixel_period(ROWS[r], p);
         end
         check_count("visible pixels in row", vga_vram_pkg::pix_count_t'(row_de),
                     vga_vram_pkg::pix_count_t'(ROWS[r].exp_vis));
      end
      if (errors == 0 && DUT.u_assertions.fail_count == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("=== FAIL ===");
         $fatal(1, "checks failed");
      end
   end

endmodule

// File: flist.f
design/vga_timing_pkg.sv
design/vga_vram_pkg.sv
design/vga_timing_gen.sv
design/vram_bank_fifo.sv
design/vram_write_distributor.sv
design/vram_read_sequencer.sv
design/vga_vram_top.sv
verification/vga_vram_assertions.sv
verification/vga_vram_tb.sv

// File: Makefile
# Verilator flow for the VGA VRAM output stage
VERILATOR  ?= verilator
TOP        ?= vga_vram_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
